// ==== rv_pkg.sv ====
package rv_pkg;

    // Datapath and register file widths
    parameter int unsigned XLEN       = 32;
    parameter int unsigned REG_ADDR_W = 5;

    // Return address offset for JAL and JALR
    parameter logic [XLEN-1:0] PC_STEP = 32'd4;

    // RV32I major opcodes
    parameter logic [6:0] OPC_LUI    = 7'b0110111;
    parameter logic [6:0] OPC_AUIPC  = 7'b0010111;
    parameter logic [6:0] OPC_JAL    = 7'b1101111;
    parameter logic [6:0] OPC_JALR   = 7'b1100111;
    parameter logic [6:0] OPC_BRANCH = 7'b1100011;
    parameter logic [6:0] OPC_LOAD   = 7'b0000011;
    parameter logic [6:0] OPC_STORE  = 7'b0100011;
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Load widths in funct3
    parameter logic [2:0] F3_LB  = 3'b000;
    parameter logic [2:0] F3_LH  = 3'b001;
    parameter logic [2:0] F3_LW  = 3'b010;
    parameter logic [2:0] F3_LBU = 3'b100;
    parameter logic [2:0] F3_LHU = 3'b101;

    // Write-back source
    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_PC4  = 2'b01,
        WB_ALU  = 2'b10,
        WB_MEM  = 2'b11
    } wb_sel_e;

    // Bundle from the memory stage, 133 bits
    // rd travels on its own next to inst
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       inst;
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       dmem_rdata;
        logic [REG_ADDR_W-1:0] rd;
    } mem_wb_t;

    // One retired instruction, 70 bits
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wdata;
        logic                  we;
    } commit_t;

endpackage

// ==== pipe_reg.sv ====
`timescale 1ns/1ns

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arst_n_i,
    input  logic valid_i,
    input  T     data_i,
    output logic valid_o,
    output T     data_o
);

    // Loads on every edge, no stall path
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            data_o  <= '0;
        end else begin
            valid_o <= valid_i;
            data_o  <= data_i;
        end
    end

    // Downstream decode trusts valid to be a clean level
    a_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !$isunknown(valid_o)
    ) else $error("pipe_reg: valid_o is unknown");

endmodule

// ==== load_align.sv ====
`timescale 1ns/1ns

module load_align (
    input  logic [rv_pkg::XLEN-1:0] word_i,
    input  logic [1:0]              offset_i,
    input  logic [2:0]              funct3_i,
    output logic [rv_pkg::XLEN-1:0] data_o
);

    import rv_pkg::*;

    logic [XLEN-1:0] shifted;
    logic [7:0]      byte_val;
    logic [15:0]     half_val;

    // Move the addressed byte down to bit 0
    assign shifted  = word_i >> {offset_i, 3'b000};
    assign byte_val = shifted[7:0];
    assign half_val = shifted[15:0];

    // A misaligned LW still sees the shifted word
    always_comb begin
        case (funct3_i)
            F3_LB: begin
                data_o = {{(XLEN-8){byte_val[7]}}, byte_val};
            end
            F3_LH: begin
                data_o = {{(XLEN-16){half_val[15]}}, half_val};
            end
            F3_LW: begin
                data_o = shifted;
            end
            F3_LBU: begin
                data_o = {{(XLEN-8){1'b0}}, byte_val};
            end
            F3_LHU: begin
                data_o = {{(XLEN-16){1'b0}}, half_val};
            end
            // Not a load width
            default: begin
                data_o = '0;
            end
        endcase
    end

endmodule

// ==== wbu.sv ====
`timescale 1ns/1ns

module wbu (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          mem_valid_i,
    input  rv_pkg::mem_wb_t               mem_bundle_i,
    output logic                          rf_we_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [rv_pkg::XLEN-1:0]       rf_wdata_o,
    output logic                          commit_valid_o,
    output rv_pkg::commit_t               commit_o
);

    import rv_pkg::*;

    logic            stage_valid;
    mem_wb_t         stage;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            op_we;
    wb_sel_e         wb_sel;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] load_data;

    // Stage register fed by the memory stage
    pipe_reg #(
        .T(mem_wb_t)
    ) u_stage_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (mem_valid_i),
        .data_i   (mem_bundle_i),
        .valid_o  (stage_valid),
        .data_o   (stage)
    );

    assign opcode   = stage.inst[6:0];
    assign funct3   = stage.inst[14:12];
    assign pc_plus4 = stage.pc + PC_STEP;

    // Byte offset comes from the low bits of the address in result
    load_align u_load_align (
        .word_i   (stage.dmem_rdata),
        .offset_i (stage.result[1:0]),
        .funct3_i (funct3),
        .data_o   (load_data)
    );

    // Opcode decode of write enable and source
    always_comb begin
        op_we  = 1'b0;
        wb_sel = WB_NONE;
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_OP, OPC_OP_IMM: begin
                op_we  = 1'b1;
                wb_sel = WB_ALU;
            end
            OPC_JAL, OPC_JALR: begin
                op_we  = 1'b1;
                wb_sel = WB_PC4;
            end
            OPC_LOAD: begin
                op_we  = 1'b1;
                wb_sel = WB_MEM;
            end
            // Stores, branches, SYSTEM and unknown opcodes retire silently
            default: begin
                op_we  = 1'b0;
                wb_sel = WB_NONE;
            end
        endcase
    end

    // Result mux
    always_comb begin
        case (wb_sel)
            WB_PC4:  rf_wdata_o = pc_plus4;
            WB_ALU:  rf_wdata_o = stage.result;
            WB_MEM:  rf_wdata_o = load_data;
            default: rf_wdata_o = '0;
        endcase
    end

    // Writes to x0 are dropped here as well as in the register file
    assign rf_we_o    = stage_valid && op_we && (stage.rd != '0);
    assign rf_waddr_o = stage.rd;

    assign commit_valid_o = stage_valid;
    assign commit_o       = '{pc: stage.pc, rd: stage.rd, wdata: rf_wdata_o, we: rf_we_o};

    // rd travels beside inst and must agree with its rd field
    a_rd_matches_inst: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (stage_valid && op_we) |-> (stage.rd == stage.inst[11:7])
    ) else $error("wbu: rd field disagrees with inst for a writing opcode");

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ns

module regfile #(
    parameter int unsigned NREGS = 32
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          we_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv_pkg::XLEN-1:0]       wdata_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [rv_pkg::XLEN-1:0]       rdata1_o,
    output logic [rv_pkg::XLEN-1:0]       rdata2_o
);

    import rv_pkg::*;

    localparam int unsigned IDX_W = $clog2(NREGS);

    logic [XLEN-1:0] regs [NREGS];

    // x0 and addresses past the last register read as zero
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] val;
        if (addr == '0 || addr >= NREGS) begin
            val = '0;
        end else begin
            val = regs[addr[IDX_W-1:0]];
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0 && waddr_i < NREGS) begin
            regs[waddr_i[IDX_W-1:0]] <= wdata_i;
        end
    end

    // Reads see the value before this cycle's write
    assign rdata1_o = read_port(raddr1_i);
    assign rdata2_o = read_port(raddr2_i);

    a_waddr_in_range: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        we_i |-> (waddr_i < NREGS)
    ) else $error("regfile: write to register %0d beyond NREGS", waddr_i);

endmodule

// ==== wb_top.sv ====
`timescale 1ns/1ns

module wb_top #(
    parameter int unsigned NREGS = 32
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          mem_valid_i,
    input  rv_pkg::mem_wb_t               mem_bundle_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    output logic                          commit_valid_o,
    output rv_pkg::commit_t               commit_o
);

    import rv_pkg::*;

    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic                  wbu_commit_valid;
    commit_t               wbu_commit;

    wbu u_wbu (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .mem_valid_i    (mem_valid_i),
        .mem_bundle_i   (mem_bundle_i),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .commit_valid_o (wbu_commit_valid),
        .commit_o       (wbu_commit)
    );

    regfile #(
        .NREGS(NREGS)
    ) u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr1_i (rs1_addr_i),
        .raddr2_i (rs2_addr_i),
        .rdata1_o (rs1_data_o),
        .rdata2_o (rs2_data_o)
    );

    // Commit record lands on the same edge as the register write
    pipe_reg #(
        .T(commit_t)
    ) u_commit_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (wbu_commit_valid),
        .data_i   (wbu_commit),
        .valid_o  (commit_valid_o),
        .data_o   (commit_o)
    );

endmodule

// ==== tb_wb_top.sv ====
`timescale 1ns/1ns

module tb_wb_top;

    import rv_pkg::*;

    localparam int unsigned NREGS   = 32;
    localparam int unsigned N_RESET = 32;
    localparam int unsigned N_ALU   = 40;
    localparam int unsigned N_JUMP  = 20;
    localparam int unsigned N_LOAD  = 32;
    localparam int unsigned N_QUIET = 40;
    localparam int unsigned N_MIX   = 200;
    localparam int unsigned DRAIN   = 3;
    // Mix strobes may each be followed by up to 3 idle cycles
    localparam int unsigned MAX_CYCLES = 10 + N_RESET + N_ALU + N_JUMP + N_LOAD + N_QUIET
                                       + 4 * N_MIX + 6 * DRAIN + 100;
    localparam logic [6:0] OPC_LIST [12] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
        OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_SYSTEM, 7'h0b, 7'h7f};

    logic                  clk;
    logic                  arst_n_i;
    logic                  mem_valid_i;
    mem_wb_t               mem_bundle_i;
    logic [REG_ADDR_W-1:0] rs1_addr_i;
    logic [REG_ADDR_W-1:0] rs2_addr_i;
    logic [XLEN-1:0]       rs1_data_o;
    logic [XLEN-1:0]       rs2_data_o;
    logic                  commit_valid_o;
    commit_t               commit_o;

    logic [31:0]           lcg_state;
    int                    err_cnt;
    int                    test_cnt;
    int                    test_err_base;
    int                    cycles;
    logic [REG_ADDR_W-1:0] last_rd;

    // Shadow model, one stage per DUT register
    logic                  s1_valid;
    commit_t               s1_commit;
    logic                  exp_valid;
    commit_t               exp_commit;
    logic [XLEN-1:0]       shadow [NREGS];
    logic [XLEN-1:0]       exp_rs1;
    logic [XLEN-1:0]       exp_rs2;

    wb_top #(
        .NREGS(NREGS)
    ) u_wb_top (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .mem_valid_i    (mem_valid_i),
        .mem_bundle_i   (mem_bundle_i),
        .rs1_addr_i     (rs1_addr_i),
        .rs2_addr_i     (rs2_addr_i),
        .rs1_data_o     (rs1_data_o),
        .rs2_data_o     (rs2_data_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected commit for one bundle, straight from the RV32I write-back rules
    function automatic commit_t expect_commit(input mem_wb_t b);
        commit_t         c;
        logic [XLEN-1:0] word;
        logic            wr;
        word    = b.dmem_rdata >> (8 * b.result[1:0]);
        c.pc    = b.pc;
        c.rd    = b.rd;
        c.wdata = '0;
        wr      = 1'b0;
        case (b.inst[6:0])
            OPC_LUI, OPC_AUIPC, OPC_OP, OPC_OP_IMM: begin
                wr      = 1'b1;
                c.wdata = b.result;
            end
            OPC_JAL, OPC_JALR: begin
                wr      = 1'b1;
                c.wdata = b.pc + 32'd4;
            end
            OPC_LOAD: begin
                wr = 1'b1;
                case (b.inst[14:12])
                    3'b000:  c.wdata = {{24{word[7]}}, word[7:0]};
                    3'b001:  c.wdata = {{16{word[15]}}, word[15:0]};
                    3'b010:  c.wdata = word;
                    3'b100:  c.wdata = {24'h0, word[7:0]};
                    3'b101:  c.wdata = {16'h0, word[15:0]};
                    default: c.wdata = '0;
                endcase
            end
            default: wr = 1'b0;
        endcase
        c.we = wr && (b.rd != '0);
        return c;
    endfunction

    function automatic mem_wb_t make_bundle(input logic [6:0] opc, input logic [2:0] f3,
                                            input logic [REG_ADDR_W-1:0] rd);
        mem_wb_t     b;
        logic [31:0] r;
        r            = lcg_next();
        b.pc         = {r[31:2], 2'b00};
        b.result     = lcg_next();
        b.dmem_rdata = lcg_next();
        r            = lcg_next();
        b.inst       = {r[31:15], f3, rd, opc};
        b.rd         = rd;
        return b;
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid   <= 1'b0;
            s1_commit  <= '0;
            exp_valid  <= 1'b0;
            exp_commit <= '0;
            for (int i = 0; i < NREGS; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            s1_valid   <= mem_valid_i;
            s1_commit  <= expect_commit(mem_bundle_i);
            exp_valid  <= s1_valid;
            exp_commit <= s1_commit;
            if (s1_valid && s1_commit.we) begin
                shadow[s1_commit.rd] <= s1_commit.wdata;
            end
        end
    end

    // shadow[0] is never written
    assign exp_rs1 = shadow[rs1_addr_i];
    assign exp_rs2 = shadow[rs2_addr_i];

    a_commit_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        commit_valid_o == exp_valid)
    else begin
        err_cnt++;
        $display("Error: commit_valid_o expected %h actual %h",
                 $sampled(exp_valid), $sampled(commit_valid_o));
    end

    a_commit_pc: assert property (@(posedge clk) disable iff (!arst_n_i)
        commit_valid_o |-> commit_o.pc == exp_commit.pc)
    else begin
        err_cnt++;
        $display("Error: commit_o.pc expected %h actual %h",
                 $sampled(exp_commit.pc), $sampled(commit_o.pc));
    end

    a_commit_rd: assert property (@(posedge clk) disable iff (!arst_n_i)
        commit_valid_o |-> commit_o.rd == exp_commit.rd)
    else begin
        err_cnt++;
        $display("Error: commit_o.rd expected %h actual %h",
                 $sampled(exp_commit.rd), $sampled(commit_o.rd));
    end

    a_commit_wdata: assert property (@(posedge clk) disable iff (!arst_n_i)
        commit_valid_o |-> commit_o.wdata == exp_commit.wdata)
    else begin
        err_cnt++;
        $display("Error: commit_o.wdata expected %h actual %h",
                 $sampled(exp_commit.wdata), $sampled(commit_o.wdata));
    end

    a_commit_we: assert property (@(posedge clk) disable iff (!arst_n_i)
        commit_valid_o |-> commit_o.we == exp_commit.we)
    else begin
        err_cnt++;
        $display("Error: commit_o.we expected %h actual %h",
                 $sampled(exp_commit.we), $sampled(commit_o.we));
    end

    a_rs1_data: assert property (@(posedge clk) disable iff (!arst_n_i)
        rs1_data_o == exp_rs1)
    else begin
        err_cnt++;
        $display("Error: rs1_data_o expected %h actual %h",
                 $sampled(exp_rs1), $sampled(rs1_data_o));
    end

    a_rs2_data: assert property (@(posedge clk) disable iff (!arst_n_i)
        rs2_data_o == exp_rs2)
    else begin
        err_cnt++;
        $display("Error: rs2_data_o expected %h actual %h",
                 $sampled(exp_rs2), $sampled(rs2_data_o));
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run went past %0d cycles without finishing", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic send(input mem_wb_t b);
        logic [31:0] r;
        @(negedge clk);
        r            = lcg_next();
        mem_valid_i  = 1'b1;
        mem_bundle_i = b;
        // rs1 reads the register that is being written in this cycle
        rs1_addr_i   = last_rd;
        rs2_addr_i   = r[4:0];
        last_rd      = b.rd;
    endtask

    task automatic idle(input int n);
        logic [31:0] r;
        repeat (n) begin
            @(negedge clk);
            r           = lcg_next();
            mem_valid_i = 1'b0;
            rs1_addr_i  = r[4:0];
            rs2_addr_i  = r[9:5];
        end
    endtask

    task automatic end_test(input string name);
        idle(DRAIN);
        test_cnt++;
        $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    initial begin
        mem_wb_t     b;
        logic [31:0] r;
        logic [6:0]  opc;
        arst_n_i      = 1'b0;
        mem_valid_i   = 1'b0;
        mem_bundle_i  = '0;
        rs1_addr_i    = '0;
        rs2_addr_i    = '0;
        lcg_state     = 32'h43a6;
        err_cnt       = 0;
        test_cnt      = 0;
        test_err_base = 0;
        cycles        = 0;
        last_rd       = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        // Every register reads zero after reset
        for (int i = 0; i < N_RESET; i++) begin
            @(negedge clk);
            rs1_addr_i = REG_ADDR_W'(i);
            rs2_addr_i = REG_ADDR_W'(N_RESET - 1 - i);
        end
        end_test("reset state");

        for (int i = 0; i < N_ALU; i++) begin
            r = lcg_next();
            case (r[1:0])
                2'd0:    opc = OPC_LUI;
                2'd1:    opc = OPC_AUIPC;
                2'd2:    opc = OPC_OP;
                default: opc = OPC_OP_IMM;
            endcase
            send(make_bundle(opc, r[4:2], r[9:5]));
        end
        end_test("alu writes");

        for (int i = 0; i < N_JUMP; i++) begin
            r = lcg_next();
            send(make_bundle(r[0] ? OPC_JAL : OPC_JALR, r[3:1], r[8:4]));
        end
        end_test("jump link");

        // All eight funct3 codes at all four byte offsets
        for (int f = 0; f < 8; f++) begin
            for (int off = 0; off < 4; off++) begin
                r             = lcg_next();
                b             = make_bundle(OPC_LOAD, 3'(f), (r[4:0] == '0) ? 5'd1 : r[4:0]);
                b.result[1:0] = 2'(off);
                send(b);
            end
        end
        end_test("load align");

        for (int i = 0; i < N_QUIET; i++) begin
            r = lcg_next();
            case (r[2:0])
                3'd0:    b = make_bundle(OPC_STORE, r[5:3], r[10:6]);
                3'd1:    b = make_bundle(OPC_BRANCH, r[5:3], r[10:6]);
                3'd2:    b = make_bundle(OPC_SYSTEM, r[5:3], r[10:6]);
                3'd3:    b = make_bundle(7'h0b, r[5:3], r[10:6]);
                3'd4:    b = make_bundle(OPC_OP, r[5:3], 5'd0);
                3'd5:    b = make_bundle(OPC_LOAD, 3'b010, 5'd0);
                3'd6:    b = make_bundle(OPC_JAL, r[5:3], 5'd0);
                default: b = make_bundle(7'h7f, r[5:3], r[10:6]);
            endcase
            send(b);
        end
        end_test("no write");

        // Random opcodes with back-to-back strobes and idle gaps
        for (int i = 0; i < N_MIX; i++) begin
            r = lcg_next();
            send(make_bundle(OPC_LIST[r[3:0] % 12], r[6:4], r[11:7]));
            if (r[13:12] != 2'd0) begin
                idle(int'(r[13:12]));
            end
        end
        end_test("mixed stream");

        $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== all.f ====
rv_pkg.sv
pipe_reg.sv
load_align.sv
wbu.sv
regfile.sv
wb_top.sv
tb_wb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_top -f all.f -o sim_wb \
    && ./obj_dir/sim_wb | tee /dev/stderr | grep -q "NO ERRORS" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
